//--- logic/netShapePkg.sv
package netShapePkg;

	// network shape.
	localparam int numFeatures = 15;
	localparam int numHidden = 8;
	localparam int numClasses = 4;

	// signed activations and weights share one width.
	localparam int dataWidth = 8;

	// 15 products of two 8-bit values plus a bias stay inside 20 signed bits.
	localparam int accWidth = 20;

	localparam int classWidth = 2; // index of one of numClasses outputs.

	// saturated activation range is 0 through actMax.
	localparam int actMax = 127;

	// input, sum and activation registers.
	localparam int layerLatency = 3;

endpackage

//--- logic/netWeightsPkg.sv
package netWeightsPkg;

	// hidden layer, one row of numFeatures weights per node.
	localparam logic [0:netShapePkg::numHidden-1][0:netShapePkg::numFeatures-1]
		[netShapePkg::dataWidth-1:0] hiddenWeights = '{
		'{8'sd12, -8'sd7, 8'sd23, 8'sd5, -8'sd18, 8'sd9, 8'sd14, -8'sd3,
			8'sd6, 8'sd11, -8'sd21, 8'sd4, 8'sd17, -8'sd9, 8'sd2},
		'{-8'sd15, 8'sd8, 8'sd3, 8'sd19, 8'sd7, -8'sd12, -8'sd4, 8'sd10,
			-8'sd16, 8'sd5, 8'sd13, -8'sd6, 8'sd1, 8'sd20, -8'sd11},
		'{8'sd4, 8'sd16, -8'sd9, -8'sd2, 8'sd11, 8'sd22, -8'sd13, 8'sd7,
			8'sd3, -8'sd19, 8'sd8, 8'sd15, -8'sd5, -8'sd1, 8'sd12},
		'{8'sd18, -8'sd3, -8'sd14, 8'sd6, 8'sd2, -8'sd8, 8'sd21, -8'sd17,
			8'sd9, 8'sd14, -8'sd2, -8'sd10, 8'sd7, 8'sd5, -8'sd20},
		'{-8'sd6, -8'sd11, 8'sd5, 8'sd13, -8'sd22, 8'sd4, 8'sd9, 8'sd16,
			-8'sd1, 8'sd7, 8'sd19, -8'sd15, 8'sd10, -8'sd4, 8'sd3},
		'{8'sd9, 8'sd2, 8'sd17, -8'sd20, 8'sd6, 8'sd15, -8'sd1, -8'sd5,
			8'sd21, -8'sd8, -8'sd12, 8'sd3, -8'sd16, 8'sd11, 8'sd8},
		'{-8'sd2, 8'sd20, -8'sd6, 8'sd8, 8'sd14, -8'sd17, 8'sd3, 8'sd12,
			-8'sd9, 8'sd1, 8'sd6, 8'sd18, -8'sd13, -8'sd7, 8'sd15},
		'{8'sd7, -8'sd14, 8'sd10, -8'sd1, -8'sd9, 8'sd13, -8'sd18, 8'sd4,
			8'sd16, 8'sd22, -8'sd3, -8'sd7, 8'sd11, 8'sd2, -8'sd5}
	};

	localparam logic [0:netShapePkg::numHidden-1][netShapePkg::dataWidth-1:0]
		hiddenBias = '{
		8'sd10, -8'sd5, 8'sd20, 8'sd0, -8'sd12, 8'sd35, 8'sd3, -8'sd8
	};

	// output layer, one row of numHidden weights per class.
	localparam logic [0:netShapePkg::numClasses-1][0:netShapePkg::numHidden-1]
		[netShapePkg::dataWidth-1:0] outWeights = '{
		'{8'sd21, -8'sd9, 8'sd14, 8'sd6, -8'sd17, 8'sd3, 8'sd11, -8'sd4},
		'{-8'sd12, 8'sd18, -8'sd5, 8'sd9, 8'sd7, -8'sd15, 8'sd4, 8'sd13},
		'{8'sd8, 8'sd5, -8'sd19, -8'sd11, 8'sd16, 8'sd10, -8'sd6, 8'sd2},
		'{-8'sd3, -8'sd14, 8'sd7, 8'sd17, -8'sd2, 8'sd12, 8'sd19, -8'sd10}
	};

	// class 0 wins on all-zero features.
	localparam logic [0:netShapePkg::numClasses-1][netShapePkg::dataWidth-1:0]
		outBias = '{
		8'sd5, -8'sd7, 8'sd40, 8'sd12
	};

endpackage

//--- logic/neuron.sv
`timescale 1ns/1ps

module neuron #(
	parameter int fanIn = netShapePkg::numFeatures,
	parameter logic [0:fanIn-1][netShapePkg::dataWidth-1:0] weights = '0,
	parameter logic signed [netShapePkg::dataWidth-1:0] bias = '0,
	parameter bit useActivation = 1'b1
) (
	input logic clk,
	input logic reset,
	input logic signed [netShapePkg::dataWidth-1:0] acts [fanIn],
	output logic signed [netShapePkg::accWidth-1:0] result
);

	logic signed [netShapePkg::dataWidth-1:0] actsReg [fanIn];
	logic signed [netShapePkg::accWidth-1:0] sumNext;
	logic signed [netShapePkg::accWidth-1:0] sumReg;
	logic signed [netShapePkg::accWidth-1:0] actOut;

	// weighted sum of the registered inputs.
	always_comb
	begin
		sumNext = netShapePkg::accWidth'(bias);
		for (int i = 0; i < fanIn; i++)
		begin
			sumNext = sumNext + netShapePkg::accWidth'(actsReg[i])
				* netShapePkg::accWidth'($signed(weights[i])); // a product needs only 16 bits.
		end
	end

	// rectify and saturate, or pass the raw sum for a score node.
	always_comb
	begin
		if (!useActivation)
			actOut = sumReg;
		else if (sumReg < 0)
			actOut = '0;
		else if (sumReg > netShapePkg::accWidth'(netShapePkg::actMax))
			actOut = netShapePkg::accWidth'(netShapePkg::actMax);
		else
			actOut = sumReg;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actsReg <= '{default: '0};
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actsReg <= acts; // stage 1.
			sumReg <= sumNext; // stage 2.
			result <= actOut; // stage 3.
		end
	end

	// the next layer keeps only dataWidth bits of an activated result.
	assert property (@(posedge clk) disable iff (reset)
		useActivation |-> (result >= 0
			&& result <= netShapePkg::accWidth'(netShapePkg::actMax)));

endmodule

//--- logic/denseLayer.sv
`timescale 1ns/1ps

module denseLayer #(
	parameter int fanIn = netShapePkg::numFeatures,
	parameter int fanOut = netShapePkg::numHidden,
	parameter logic [0:fanOut-1][0:fanIn-1][netShapePkg::dataWidth-1:0] weights = '0,
	parameter logic [0:fanOut-1][netShapePkg::dataWidth-1:0] biases = '0,
	parameter bit useActivation = 1'b1
) (
	input logic clk,
	input logic reset,
	input logic signed [netShapePkg::dataWidth-1:0] acts [fanIn],
	input logic inValid,
	output logic signed [netShapePkg::accWidth-1:0] results [fanOut],
	output logic outValid
);

	logic [netShapePkg::layerLatency-1:0] validPipe;

	// every node sees the same vector with its own weight row.
	for (genvar n = 0; n < fanOut; n++)
	begin : gNode
		neuron #(
			.fanIn(fanIn),
			.weights(weights[n]),
			.bias(biases[n]),
			.useActivation(useActivation)
		) i_node (
			.clk(clk),
			.reset(reset),
			.acts(acts),
			.result(results[n])
		);
	end

	// valid moves with the data through the three node stages.
	always_ff @(posedge clk)
	begin
		if (reset)
			validPipe <= '0;
		else
			validPipe <= {validPipe[netShapePkg::layerLatency-2:0], inValid};
	end

	assign outValid = validPipe[netShapePkg::layerLatency-1];

	// the nodes hold no valid of their own, so the pipe must match their depth.
	assert property (@(posedge clk) disable iff (reset)
		inValid |-> ##(netShapePkg::layerLatency) outValid);

endmodule

//--- logic/argmaxUnit.sv
`timescale 1ns/1ps

module argmaxUnit (
	input logic clk,
	input logic reset,
	input logic signed [netShapePkg::accWidth-1:0] scores [netShapePkg::numClasses],
	input logic inValid,
	output logic [netShapePkg::classWidth-1:0] classIdx,
	output logic outValid
);

	logic [netShapePkg::classWidth-1:0] bestIdx;
	logic signed [netShapePkg::accWidth-1:0] bestScore;

	// linear scan over the classes.
	always_comb
	begin
		bestIdx = '0;
		bestScore = scores[0];
		for (int c = 1; c < netShapePkg::numClasses; c++)
		begin
			if (scores[c] > bestScore) // strict, a tie keeps the lower index.
			begin
				bestIdx = netShapePkg::classWidth'(c);
				bestScore = scores[c];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			classIdx <= '0;
			outValid <= 1'b0;
		end
		else
		begin
			classIdx <= bestIdx;
			outValid <= inValid;
		end
	end

	// no class beats the chosen one and an equal score never sits at a lower index.
	for (genvar c = 0; c < netShapePkg::numClasses; c++)
	begin : gCheck
		assert property (@(posedge clk) disable iff (reset)
			inValid |-> (scores[c] < scores[bestIdx]
				|| (scores[c] == scores[bestIdx] && int'(bestIdx) <= c)));
	end

endmodule

//--- logic/mlpClassifier.sv
`timescale 1ns/1ps

module mlpClassifier (
	input logic clk,
	input logic reset,
	input logic signed [netShapePkg::dataWidth-1:0] features [netShapePkg::numFeatures],
	input logic inValid,
	output logic signed [netShapePkg::accWidth-1:0] scores [netShapePkg::numClasses],
	output logic [netShapePkg::classWidth-1:0] classIdx,
	output logic outValid
);

	logic signed [netShapePkg::accWidth-1:0] hiddenWide [netShapePkg::numHidden];
	logic signed [netShapePkg::dataWidth-1:0] hiddenAct [netShapePkg::numHidden];
	logic hiddenValid;
	logic scoreValid;

	denseLayer #(
		.fanIn(netShapePkg::numFeatures),
		.fanOut(netShapePkg::numHidden),
		.weights(netWeightsPkg::hiddenWeights),
		.biases(netWeightsPkg::hiddenBias),
		.useActivation(1'b1)
	) i_hidden (
		.clk(clk),
		.reset(reset),
		.acts(features),
		.inValid(inValid),
		.results(hiddenWide),
		.outValid(hiddenValid)
	);

	// activation bounds the hidden results to 0..actMax.
	for (genvar h = 0; h < netShapePkg::numHidden; h++)
	begin : gNarrow
		assign hiddenAct[h] = hiddenWide[h][netShapePkg::dataWidth-1:0];
	end

	denseLayer #(
		.fanIn(netShapePkg::numHidden),
		.fanOut(netShapePkg::numClasses),
		.weights(netWeightsPkg::outWeights),
		.biases(netWeightsPkg::outBias),
		.useActivation(1'b0)
	) i_output (
		.clk(clk),
		.reset(reset),
		.acts(hiddenAct),
		.inValid(hiddenValid),
		.results(scores),
		.outValid(scoreValid)
	);

	argmaxUnit i_argmax (
		.clk(clk),
		.reset(reset),
		.scores(scores),
		.inValid(scoreValid),
		.classIdx(classIdx),
		.outValid(outValid)
	);

endmodule

//--- dv/mlpModel.svh
`ifndef MLPMODEL_SVH
`define MLPMODEL_SVH

	// rectified and saturated hidden activation.
	function automatic int clampActivation(input int sum);
		if (sum < 0)
			return 0;
		if (sum > netShapePkg::actMax)
			return netShapePkg::actMax;
		return sum;
	endfunction

	// both layers in plain integer arithmetic, so nothing can wrap.
	function automatic void runNetwork(
		input logic signed [netShapePkg::dataWidth-1:0] feat [netShapePkg::numFeatures],
		output int score [netShapePkg::numClasses]
	);
		int hidden [netShapePkg::numHidden];
		int sum;
		for (int h = 0; h < netShapePkg::numHidden; h++)
		begin
			sum = int'($signed(netWeightsPkg::hiddenBias[h]));
			for (int f = 0; f < netShapePkg::numFeatures; f++)
			begin
				sum += int'($signed(netWeightsPkg::hiddenWeights[h][f])) * int'(feat[f]);
			end
			hidden[h] = clampActivation(sum);
		end
		for (int c = 0; c < netShapePkg::numClasses; c++)
		begin
			sum = int'($signed(netWeightsPkg::outBias[c]));
			for (int h = 0; h < netShapePkg::numHidden; h++)
			begin
				sum += int'($signed(netWeightsPkg::outWeights[c][h])) * hidden[h];
			end
			score[c] = sum; // raw score, no activation.
		end
	endfunction

	// highest score wins.
	function automatic int pickClass(input int score [netShapePkg::numClasses]);
		int best;
		best = 0;
		for (int c = 1; c < netShapePkg::numClasses; c++)
		begin
			if (score[c] > score[best]) // equal scores keep the lower index.
				best = c;
		end
		return best;
	endfunction

`endif

//--- dv/mlpClassifierTb.sv
`timescale 1ns/1ps

module mlpClassifierTb;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 4;
	localparam int burstLen = 200;
	localparam int dutyLen = 200;
	localparam int pipeDepth = 7; // hidden, output and argmax.
	localparam int scoreDepth = 6;
	localparam int extraCycles = 80; // directed samples, idle gaps and drain.
	localparam int watchdogCycles = resetCycles + burstLen + dutyLen + extraCycles + 100;

	// feature fill patterns.
	localparam int fillRandom = 0;
	localparam int fillZero = 1;
	localparam int fillLow = 2;
	localparam int fillHigh = 3;

	typedef struct packed {
		logic [netShapePkg::numClasses-1:0][31:0] score;
		logic [31:0] cls;
		logic [31:0] cycle;
	} expectT;

	logic clk;
	logic reset;
	logic signed [netShapePkg::dataWidth-1:0] features [netShapePkg::numFeatures];
	logic inValid;
	logic signed [netShapePkg::accWidth-1:0] scores [netShapePkg::numClasses];
	logic [netShapePkg::classWidth-1:0] classIdx;
	logic outValid;

	expectT expectQ [$];
	int errorCount = 0;
	int checkCount = 0;
	int cycleCount = 0;
	int strobeCount = 0;
	int resultCount = 0;

	`include "mlpModel.svh"

	mlpClassifier i_dut (
		.clk(clk),
		.reset(reset),
		.features(features),
		.inValid(inValid),
		.scores(scores),
		.classIdx(classIdx),
		.outValid(outValid)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	task automatic reportValue(input string name, input int expected, input int actual);
		errorCount++;
		$display("Error at %0t ns: %s expected %0d, actual %0d", $time, name, expected, actual);
	endtask

	task automatic reportFailure(input string what);
		errorCount++;
		$display("Failure at %0t ns: %s", $time, what);
	endtask

	// one clock of stimulus.
	task automatic driveCycle(input bit strobe, input int fill);
		logic signed [netShapePkg::dataWidth-1:0] value;
		@(posedge clk);
		for (int f = 0; f < netShapePkg::numFeatures; f++)
		begin
			case (fill)
				fillZero: value = '0;
				fillLow: value = 8'h80;
				fillHigh: value = 8'h7f;
				default: value = 8'($urandom());
			endcase
			features[f] <= value;
		end
		inValid <= strobe;
	endtask

	// outputs are sampled mid-cycle, away from the driving edge.
	always @(negedge clk)
	begin : monitor
		expectT head;
		expectT entry;
		int modelScores [netShapePkg::numClasses];
		int actual;
		cycleCount++;
		if (!reset)
		begin
			if (outValid)
			begin
				if (expectQ.size() == 0)
					reportFailure("outValid went high with no strobed sample waiting");
				else
				begin
					head = expectQ.pop_front();
					resultCount++;
					checkCount++;
					if (cycleCount - int'(head.cycle) != pipeDepth)
						reportValue("outValid latency", pipeDepth, cycleCount - int'(head.cycle));
					if (classIdx !== head.cls[netShapePkg::classWidth-1:0])
						reportValue("classIdx", int'(head.cls), int'(classIdx));
				end
			end
			// after the pop the front entry is the one now at the scores.
			if (i_dut.scoreValid)
			begin
				if (expectQ.size() == 0)
					reportFailure("scoreValid went high with no strobed sample waiting");
				else
				begin
					head = expectQ[0];
					checkCount++;
					if (cycleCount - int'(head.cycle) != scoreDepth)
						reportValue("scoreValid latency", scoreDepth, cycleCount - int'(head.cycle));
					for (int c = 0; c < netShapePkg::numClasses; c++)
					begin
						actual = int'(scores[c]);
						if (actual != int'($signed(head.score[c])))
							reportValue($sformatf("scores[%0d]", c), int'($signed(head.score[c])),
								actual);
					end
				end
			end
			if (inValid)
			begin
				runNetwork(features, modelScores);
				for (int c = 0; c < netShapePkg::numClasses; c++)
					entry.score[c] = modelScores[c];
				entry.cls = pickClass(modelScores);
				entry.cycle = cycleCount;
				expectQ.push_back(entry);
				strobeCount++;
			end
		end
	end

	initial
	begin : stimulus
		void'($urandom(32'hedd8_3f5b));
		reset = 1'b1;
		inValid = 1'b0;
		for (int f = 0; f < netShapePkg::numFeatures; f++)
			features[f] = '0;
		repeat (resetCycles) @(posedge clk);
		reset <= 1'b0;

		// quiet after reset, then one all-zero sample decided by the output biases.
		repeat (10) driveCycle(1'b0, fillRandom);
		driveCycle(1'b1, fillZero);
		repeat (10) driveCycle(1'b0, fillRandom);

		repeat (burstLen) driveCycle(1'b1, fillRandom); // a sample every cycle.
		repeat (10) driveCycle(1'b0, fillRandom);

		// about half the cycles strobed.
		repeat (dutyLen) driveCycle(1'($urandom()), fillRandom);

		// extremes, back to back and then alone.
		driveCycle(1'b1, fillLow);
		driveCycle(1'b1, fillHigh);
		driveCycle(1'b1, fillZero);
		driveCycle(1'b1, fillLow);
		repeat (10) driveCycle(1'b0, fillRandom);
		driveCycle(1'b1, fillHigh);
		driveCycle(1'b0, fillZero);

		while (expectQ.size() != 0)
			@(posedge clk);
		repeat (10) @(posedge clk); // catch any stray valid.

		if (strobeCount != resultCount)
			reportFailure($sformatf("%0d samples strobed but %0d results seen",
				strobeCount, resultCount));
		$display("samples %0d, checks %0d, errors %0d", strobeCount, checkCount, errorCount);
		if (errorCount == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin : watchdog
		#(watchdogCycles * clkPeriod);
		$display("Timeout: the run did not finish within %0d cycles", watchdogCycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

//--- build.f
+incdir+dv
logic/netShapePkg.sv
logic/netWeightsPkg.sv
logic/neuron.sv
logic/denseLayer.sv
logic/argmaxUnit.sv
logic/mlpClassifier.sv
dv/mlpClassifierTb.sv

//--- Makefile
SOURCES := $(wildcard logic/*.sv) dv/mlpClassifierTb.sv dv/mlpModel.svh

.PHONY: run clean

obj_dir/VmlpClassifierTb: build.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/1ps -j 0 \
		--top-module mlpClassifierTb -Mdir obj_dir -f build.f

run: obj_dir/VmlpClassifierTb
	@out="$$(./obj_dir/VmlpClassifierTb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir
